/* hdl/softreg_pkg.sv */
/*
  Shared widths and word layouts for the soft-register fabric.
  Request and response structs travel through every pipe, bank and
  merge stage. Modules pull these in with a wildcard import.
*/

package softreg_pkg;

	// --------------------
	// Widths
	// --------------------

	// Full host address and data word
	localparam int SR_ADDR_W = 32;
	localparam int SR_DATA_W = 64;

	// Address bits that pick a bank, then a register in that bank
	localparam int BANK_SEL_W = 8;
	localparam int REG_SEL_W  = 8;

	// Leftover upper bits must be zero on a valid access
	localparam int UNUSED_HI_W = SR_ADDR_W - BANK_SEL_W - REG_SEL_W;

	// --------------------
	// Address view
	// --------------------

	// Split of a host address with the upper bits first
	typedef struct packed {
		logic [UNUSED_HI_W-1:0] unused_hi;
		logic [BANK_SEL_W-1:0]  bank_sel;
		logic [REG_SEL_W-1:0]   reg_sel;
	} sr_addr_t;

	// --------------------
	// Request and response
	// --------------------

	// Host request that exists only in cycles where valid is set
	typedef struct packed {
		logic                 valid;
		logic                 is_write;
		sr_addr_t             addr;
		logic [SR_DATA_W-1:0] data;
	} softreg_req_t;

	// Read response that stays all zero when idle so responses can be OR-merged
	typedef struct packed {
		logic                 valid;
		logic [SR_DATA_W-1:0] data;
	} softreg_resp_t;

endpackage

/* hdl/pipe_delay.sv */
/*
  Register delay line for a packed word of any width.
  Output follows the input STAGES cycles later; every stage clears
  to zero in reset so a delayed valid bit starts low.
*/

`timescale 1ns/1ns

module pipe_delay #(
	parameter int WIDTH  = 1,
	parameter int STAGES = 1
) (
	input  logic             global_clk,
	input  logic             global_rst_n,
	input  logic [WIDTH-1:0] in_bus,
	output logic [WIDTH-1:0] out_bus
);

	generate
		if (STAGES == 0) begin : gen_no_delay
			// Zero stages collapses to a plain connection
			assign out_bus = in_bus;
		end else begin : gen_delay
			logic [WIDTH-1:0] stage_q [STAGES];

			// Reset is active high
			always_ff @(posedge global_clk) begin
				if (global_rst_n) begin
					for (int s = 0; s < STAGES; s++) begin
						stage_q[s] <= '0;
					end
				end else begin
					stage_q[0] <= in_bus;
					for (int s = 1; s < STAGES; s++) begin
						stage_q[s] <= stage_q[s-1];
					end
				end
			end

			assign out_bus = stage_q[STAGES-1];
		end
	endgenerate

endmodule

/* hdl/softreg_bank.sv */
/*
  One bank of soft registers on the broadcast request bus.
  Acts only on requests whose address selects this bank and an existing
  register. Writes land at the request edge; reads answer one cycle later.
  An idle bank drives an all-zero response for the OR merge downstream.
*/

`timescale 1ns/1ns

module softreg_bank import softreg_pkg::*; #(
	parameter int BANK_ID       = 0,
	parameter int REGS_PER_BANK = 8
) (
	input  logic          global_clk,
	input  logic          global_rst_n,
	input  softreg_req_t  req,
	output softreg_resp_t resp
);

	// Index width into the register file is at least one bit
	localparam int REG_IDX_W = (REGS_PER_BANK > 1) ? $clog2(REGS_PER_BANK) : 1;

	// --------------------
	// Address decode
	// --------------------

	sr_addr_t              req_addr;
	logic                  bank_hit;
	logic                  reg_hit;
	logic                  access_hit;
	logic                  wr_hit;
	logic                  rd_hit;
	logic [REG_IDX_W-1:0]  reg_idx;

	assign req_addr = req.addr;

	// Upper bits must be clear and the bank number must be ours
	assign bank_hit = (req_addr.unused_hi == '0) &&
		(req_addr.bank_sel == BANK_SEL_W'(BANK_ID));

	// Registers past the end of the file are not decoded
	assign reg_hit = (int'(req_addr.reg_sel) < REGS_PER_BANK);

	assign access_hit = req.valid && bank_hit && reg_hit;
	assign wr_hit     = access_hit && req.is_write;
	assign rd_hit     = access_hit && !req.is_write;

	assign reg_idx = req_addr.reg_sel[REG_IDX_W-1:0];

	// --------------------
	// Register file and read port
	// --------------------

	logic [SR_DATA_W-1:0] regs_q [REGS_PER_BANK];

	// Registers read back as zero after reset
	always_ff @(posedge global_clk) begin
		if (global_rst_n) begin
			for (int r = 0; r < REGS_PER_BANK; r++) begin
				regs_q[r] <= '0;
			end
		end else if (wr_hit) begin
			regs_q[reg_idx] <= req.data;
		end
	end

	// Response is zero in every cycle without a matching read
	always_ff @(posedge global_clk) begin
		if (global_rst_n) begin
			resp <= '0;
		end else if (rd_hit) begin
			resp.valid <= 1'b1;
			resp.data  <= regs_q[reg_idx];
		end else begin
			resp <= '0;
		end
	end

endmodule

/* hdl/resp_or_tree.sv */
/*
  Merges the bank responses into one through a registered OR tree.
  Leaves are registered first, then each level ORs pairs into registers,
  so the root lags the inputs by 1 + log2(NUM_BANKS) cycles.
  Relies on at most one bank answering in any cycle.
*/

`timescale 1ns/1ns

module resp_or_tree import softreg_pkg::*; #(
	parameter int NUM_BANKS = 4
) (
	input  logic          global_clk,
	input  logic          global_rst_n,
	input  softreg_resp_t leaf_resp [NUM_BANKS],
	output softreg_resp_t root_resp
);

	// Heap layout with the root at 0 and the children of n at 2n+1 and 2n+2
	localparam int NUM_NODES = 2 * NUM_BANKS - 1;

	// First leaf slot equals the number of inner nodes
	localparam int LEAF_BASE = NUM_BANKS - 1;

	softreg_resp_t node_q [NUM_NODES];

	// --------------------
	// Leaf and merge stages
	// --------------------

	// All levels advance together, so every leaf sees the same depth
	always_ff @(posedge global_clk) begin
		if (global_rst_n) begin
			for (int n = 0; n < NUM_NODES; n++) begin
				node_q[n] <= '0;
			end
		end else begin
			// Leaf stage
			for (int b = 0; b < NUM_BANKS; b++) begin
				node_q[LEAF_BASE + b] <= leaf_resp[b];
			end

			// Inner nodes take the OR of their two children
			for (int n = 0; n < LEAF_BASE; n++) begin
				node_q[n] <= node_q[2*n + 1] | node_q[2*n + 2];
			end
		end
	end

	assign root_resp = node_q[0];

endmodule

/* hdl/softreg_fabric_top.sv */
/*
  Top level of the soft-register fabric.
  Host requests are retimed, broadcast to every bank, and the bank
  answers are OR-merged and retimed back out. A read returns after
  REQ_STAGES + 2 + log2(NUM_BANKS) + RESP_STAGES cycles; writes are silent.
*/

`timescale 1ns/1ns

module softreg_fabric_top import softreg_pkg::*; #(
	parameter int NUM_BANKS     = 4,
	parameter int REGS_PER_BANK = 8,
	parameter int REQ_STAGES    = 2,
	parameter int RESP_STAGES   = 2
) (
	input  logic          global_clk,
	input  logic          global_rst_n,
	input  softreg_req_t  softreg_req,
	output softreg_resp_t softreg_resp
);

	// Request after the input pipe as seen by every bank
	softreg_req_t  bank_req;

	// One response per bank that stays zero unless that bank answers
	softreg_resp_t bank_resp [NUM_BANKS];

	// Merged response ahead of the output pipe
	softreg_resp_t tree_resp;

	// --------------------
	// Request pipe
	// --------------------

	pipe_delay #(
		.WIDTH($bits(softreg_req_t)),
		.STAGES(REQ_STAGES)
	) req_pipe (
		.global_clk(global_clk),
		.global_rst_n(global_rst_n),
		.in_bus(softreg_req),
		.out_bus(bank_req)
	);

	// --------------------
	// Banks
	// --------------------

	// Each bank decodes its own number from the broadcast address
	genvar b;
	generate
		for (b = 0; b < NUM_BANKS; b++) begin : gen_bank
			softreg_bank #(
				.BANK_ID(b),
				.REGS_PER_BANK(REGS_PER_BANK)
			) bank (
				.global_clk(global_clk),
				.global_rst_n(global_rst_n),
				.req(bank_req),
				.resp(bank_resp[b])
			);
		end
	endgenerate

	// --------------------
	// Response merge and pipe
	// --------------------

	resp_or_tree #(
		.NUM_BANKS(NUM_BANKS)
	) resp_tree (
		.global_clk(global_clk),
		.global_rst_n(global_rst_n),
		.leaf_resp(bank_resp),
		.root_resp(tree_resp)
	);

	pipe_delay #(
		.WIDTH($bits(softreg_resp_t)),
		.STAGES(RESP_STAGES)
	) resp_pipe (
		.global_clk(global_clk),
		.global_rst_n(global_rst_n),
		.in_bus(tree_resp),
		.out_bus(softreg_resp)
	);

endmodule

/* dv/softreg_fabric_checker.sv */
/*
  Bound assertions on the fabric's outer request and response timing.
  Attached to every softreg_fabric_top by the bind at the bottom.
  A read to an existing register must come back exactly LAT cycles later.
*/

`timescale 1ns/1ns

module softreg_fabric_checker import softreg_pkg::*; #(
	parameter int NUM_BANKS     = 4,
	parameter int REGS_PER_BANK = 8,
	parameter int REQ_STAGES    = 2,
	parameter int RESP_STAGES   = 2
) (
	input logic          global_clk,
	input logic          global_rst_n,
	input softreg_req_t  softreg_req,
	input softreg_resp_t softreg_resp
);

	// Request pipe, bank, tree leaf and levels, response pipe
	localparam int LAT = REQ_STAGES + 1 + 1 + $clog2(NUM_BANKS) + RESP_STAGES;

	// Failed property count read by the testbench
	int fail_count = 0;

	logic rd_hit;

	// Read that some bank will answer while out of reset
	assign rd_hit = !global_rst_n && softreg_req.valid && !softreg_req.is_write &&
		(softreg_req.addr.unused_hi == '0) &&
		(int'(softreg_req.addr.bank_sel) < NUM_BANKS) &&
		(int'(softreg_req.addr.reg_sel) < REGS_PER_BANK);

	// --------------------
	// Properties
	// --------------------

	quiet_after_reset: assert property (@(posedge global_clk)
		$fell(global_rst_n) |-> !softreg_resp.valid)
		else begin
			fail_count++;
			$error("response valid in the first cycle after reset");
		end

	read_answered: assert property (@(posedge global_clk) disable iff (global_rst_n)
		$past(rd_hit, LAT) |-> softreg_resp.valid)
		else begin
			fail_count++;
			$error("in-range read got no response at the expected latency");
		end

	no_spurious_resp: assert property (@(posedge global_clk) disable iff (global_rst_n)
		softreg_resp.valid |-> $past(rd_hit, LAT))
		else begin
			fail_count++;
			$error("response valid without a matching read");
		end

endmodule

bind softreg_fabric_top softreg_fabric_checker #(
	.NUM_BANKS(NUM_BANKS),
	.REGS_PER_BANK(REGS_PER_BANK),
	.REQ_STAGES(REQ_STAGES),
	.RESP_STAGES(RESP_STAGES)
) chk0 (
	.global_clk(global_clk),
	.global_rst_n(global_rst_n),
	.softreg_req(softreg_req),
	.softreg_resp(softreg_resp)
);

/* dv/softreg_fabric_tb.sv */
/*
  Testbench for the soft-register fabric.
  Drives random host requests on the falling edge and checks every
  response cycle against a register model and a queue of due reads.
*/

`timescale 1ns/1ns

module softreg_fabric_tb import softreg_pkg::*; ();

	localparam int NUM_BANKS     = 4;
	localparam int REGS_PER_BANK = 8;
	localparam int REQ_STAGES    = 2;
	localparam int RESP_STAGES   = 2;

	localparam int LAT = REQ_STAGES + 1 + 1 + $clog2(NUM_BANKS) + RESP_STAGES;
	localparam int BANK_IDX_W = $clog2(NUM_BANKS);
	localparam int REG_IDX_W  = $clog2(REGS_PER_BANK);
	localparam int NUM_REGS   = NUM_BANKS * REGS_PER_BANK;

	// Test lengths in cycles
	localparam int DRAIN_CYCLES = LAT + 2;
	localparam int WR_CYCLES    = 60;
	localparam int B2B_PAIRS    = 30;
	localparam int OOR_CYCLES   = 60;
	localparam int SILENT_CYCLES = 50;

	// Write-read may need one extra read per write for leftovers
	localparam int TOTAL_CYCLES = 4 + (4 + NUM_REGS) + 2 * WR_CYCLES + 2 * B2B_PAIRS +
		(OOR_CYCLES + NUM_REGS) + SILENT_CYCLES + 5 * DRAIN_CYCLES;
	localparam int CYCLE_LIMIT = TOTAL_CYCLES + LAT + 20;

	logic          global_clk;
	logic          global_rst_n;
	softreg_req_t  softreg_req;
	softreg_resp_t softreg_resp;

	int seed;
	int cycle = 0;
	int errors = 0;
	int checks = 0;
	int errs_at_start = 0;
	int tests_run = 0;
	int tests_failed = 0;

	// Reference model
	logic [SR_DATA_W-1:0] model_regs [NUM_BANKS][REGS_PER_BANK];
	int                   exp_due[$];
	logic [SR_DATA_W-1:0] exp_data[$];

	softreg_fabric_top #(
		.NUM_BANKS(NUM_BANKS),
		.REGS_PER_BANK(REGS_PER_BANK),
		.REQ_STAGES(REQ_STAGES),
		.RESP_STAGES(RESP_STAGES)
	) dut0 (
		.global_clk(global_clk),
		.global_rst_n(global_rst_n),
		.softreg_req(softreg_req),
		.softreg_resp(softreg_resp)
	);

	always #50 global_clk = ~global_clk;

	// Cycle count that also ends a runaway run
	always @(posedge global_clk) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("Timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
			$display("Some tests failed");
			$finish;
		end
	end

	// --------------------
	// Helpers
	// --------------------

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % 32'(n));
	endfunction

	function automatic logic [SR_DATA_W-1:0] rand_data();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic bit in_range(input sr_addr_t a);
		return (a.unused_hi == '0) && (int'(a.bank_sel) < NUM_BANKS) &&
			(int'(a.reg_sel) < REGS_PER_BANK);
	endfunction

	function automatic sr_addr_t make_addr(input int bank, input int rsel);
		sr_addr_t a;
		a.unused_hi = '0;
		a.bank_sel  = BANK_SEL_W'(bank);
		a.reg_sel   = REG_SEL_W'(rsel);
		return a;
	endfunction

	function automatic sr_addr_t rand_good_addr();
		return make_addr(rand_below(NUM_BANKS), rand_below(REGS_PER_BANK));
	endfunction

	// Breaks exactly one of the three address rules
	function automatic sr_addr_t rand_bad_addr();
		sr_addr_t a;
		a = rand_good_addr();
		case (rand_below(3))
			0: a.unused_hi = UNUSED_HI_W'(1 + rand_below(2**UNUSED_HI_W - 1));
			1: a.bank_sel = BANK_SEL_W'(NUM_BANKS + rand_below(2**BANK_SEL_W - NUM_BANKS));
			default: a.reg_sel = REG_SEL_W'(REGS_PER_BANK +
				rand_below(2**REG_SEL_W - REGS_PER_BANK));
		endcase
		return a;
	endfunction

	function automatic softreg_req_t make_req(input logic is_write, input sr_addr_t addr,
			input logic [SR_DATA_W-1:0] data);
		softreg_req_t r;
		r.valid    = 1'b1;
		r.is_write = is_write;
		r.addr     = addr;
		r.data     = data;
		return r;
	endfunction

	task automatic compare(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("Error: %s = 0x%h, expected 0x%h (cycle %0d)",
				name, got, expected, cycle);
		end
	endtask

	// Check the output, then drive the next request and update the model
	task automatic step(input softreg_req_t req);
		logic                  exp_valid;
		logic [BANK_IDX_W-1:0] bank_idx;
		logic [REG_IDX_W-1:0]  reg_idx;
		@(negedge global_clk);
		exp_valid = (exp_due.size() > 0) && (exp_due[0] == cycle);
		compare("softreg_resp.valid", 64'(softreg_resp.valid), 64'(exp_valid));
		if (exp_valid) begin
			compare("softreg_resp.data", softreg_resp.data, exp_data[0]);
			void'(exp_due.pop_front());
			void'(exp_data.pop_front());
		end
		softreg_req = req;
		bank_idx = req.addr.bank_sel[BANK_IDX_W-1:0];
		reg_idx  = req.addr.reg_sel[REG_IDX_W-1:0];
		if (req.valid && in_range(req.addr)) begin
			if (req.is_write) begin
				model_regs[bank_idx][reg_idx] = req.data;
			end else begin
				exp_due.push_back(cycle + LAT);
				exp_data.push_back(model_regs[bank_idx][reg_idx]);
			end
		end
	endtask

	task automatic idle();
		step('0);
	endtask

	task automatic read_all();
		for (int b = 0; b < NUM_BANKS; b++) begin
			for (int r = 0; r < REGS_PER_BANK; r++) begin
				step(make_req(1'b0, make_addr(b, r), '0));
			end
		end
	endtask

	task automatic finish_test(input string name);
		int new_errs;
		repeat (DRAIN_CYCLES) idle();
		if (exp_due.size() != 0) begin
			errors++;
			$display("%0d expected read responses never arrived", exp_due.size());
			exp_due.delete();
			exp_data.delete();
		end
		new_errs = errors - errs_at_start;
		tests_run++;
		if (new_errs != 0) begin
			tests_failed++;
		end
		$display("Test %0d %s: %s, %0d errors", tests_run, name,
			(new_errs == 0) ? "pass" : "FAIL", new_errs);
		errs_at_start = errors;
	endtask

	// --------------------
	// Tests
	// --------------------

	task automatic test_after_reset();
		repeat (4) idle();
		read_all();
		finish_test("after_reset");
	endtask

	task automatic test_write_read();
		sr_addr_t pending[$];
		sr_addr_t a;
		for (int i = 0; i < WR_CYCLES; i++) begin
			if (rand_below(100) < 30) begin
				idle();
			end else if (pending.size() == 0 || rand_below(2) == 0) begin
				a = rand_good_addr();
				pending.push_back(a);
				step(make_req(1'b1, a, rand_data()));
			end else begin
				step(make_req(1'b0, pending.pop_front(), '0));
			end
		end
		while (pending.size() > 0) begin
			step(make_req(1'b0, pending.pop_front(), '0));
		end
		finish_test("write_read");
	endtask

	// Every pair ends in a read with no idle cycles between
	task automatic test_back_to_back();
		sr_addr_t a;
		for (int i = 0; i < B2B_PAIRS; i++) begin
			a = rand_good_addr();
			case (rand_below(3))
				0: step(make_req(1'b1, a, rand_data()));
				1: step(make_req(1'b0, a, '0));
				default: step(make_req(1'b1, rand_good_addr(), rand_data()));
			endcase
			step(make_req(1'b0, a, '0));
		end
		finish_test("back_to_back");
	endtask

	task automatic test_out_of_range();
		for (int i = 0; i < OOR_CYCLES; i++) begin
			if (rand_below(100) < 30) begin
				idle();
			end else begin
				step(make_req(rand_below(2) == 1, rand_bad_addr(), rand_data()));
			end
		end
		// Register contents must match a model that ignored those writes
		read_all();
		finish_test("out_of_range");
	endtask

	task automatic test_writes_silent();
		for (int i = 0; i < SILENT_CYCLES; i++) begin
			if (rand_below(100) < 30) begin
				idle();
			end else begin
				step(make_req(1'b1, rand_good_addr(), rand_data()));
			end
		end
		finish_test("writes_silent");
	endtask

	// --------------------
	// Main sequence
	// --------------------

	initial begin
		seed = 35800;
		global_clk = 1'b0;
		global_rst_n = 1'b1;
		softreg_req = '0;
		for (int b = 0; b < NUM_BANKS; b++) begin
			for (int r = 0; r < REGS_PER_BANK; r++) begin
				model_regs[b][r] = '0;
			end
		end

		// Active-high reset released on a falling edge
		repeat (3) @(posedge global_clk);
		@(negedge global_clk);
		global_rst_n = 1'b0;

		test_after_reset();
		test_write_read();
		test_back_to_back();
		test_out_of_range();
		test_writes_silent();

		if (dut0.chk0.fail_count != 0) begin
			errors = errors + dut0.chk0.fail_count;
			$display("Bound timing assertions failed %0d times", dut0.chk0.fail_count);
		end

		$display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* vlog.f */
hdl/softreg_pkg.sv
hdl/pipe_delay.sv
hdl/softreg_bank.sv
hdl/resp_or_tree.sv
hdl/softreg_fabric_top.sv
dv/softreg_fabric_checker.sv
dv/softreg_fabric_tb.sv

/* run.sh */
#!/bin/bash
# Build the fabric testbench with Verilator and run it.
# Exit status is 0 only when the pass message shows up in the output.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module softreg_fabric_tb -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -q "All tests passed" &&
echo "Simulation result: PASS" ||
{ echo "Simulation result: FAIL"; exit 1; }
